// File: design/mac_width_pkg.sv
package mac_width_pkg;

    // ----------------------------------------------------------------------
    // Datapath widths of the multiply-add slice
    // ----------------------------------------------------------------------

    // Operand ports a and b, as on the DSP48A1 A/B inputs
    parameter int DEF_AB_W = 18;            // Signed a and b

    // Wide side of the slice holds c, the a:b concat and the result p.
    // Each stage derives the product width as 2*AB_W itself
    parameter int DEF_P_W  = 48;            // Signed c, concat and p

endpackage : mac_width_pkg

// File: design/mac_opcode_pkg.sv
package mac_opcode_pkg;

    // ----------------------------------------------------------------------
    // Op word layout, one field map for the whole engine
    // ----------------------------------------------------------------------

    parameter int OP_POST_SUB = 7;          // Postadder subtracts, Z - (X + cin)
    parameter int OP_PRE_SUB  = 6;          // Preadder negates b
    parameter int OP_CARRY_IN = 5;          // Add 1 in the postadder
    parameter int OP_USE_PRE  = 4;          // Route b through the preadder

    parameter int OP_Z_HI     = 3;          // Z source field upper bit
    parameter int OP_Z_LO     = 2;          // Z source field lower bit
    parameter int OP_X_HI     = 1;          // X source field upper bit
    parameter int OP_X_LO     = 0;          // X source field lower bit

    // 2-bit select for either postadder mux
    typedef logic [1:0] sel_t;

    // ----------------------------------------------------------------------
    // X mux sources
    // ----------------------------------------------------------------------
    parameter sel_t X_ZERO    = 2'd0;       // Constant zero
    parameter sel_t X_MULT    = 2'd1;       // Sign-extended product
    parameter sel_t X_PREV_P  = 2'd2;       // Current p
    parameter sel_t X_CONCAT  = 2'd3;       // a:b zero-extended

    // ----------------------------------------------------------------------
    // Z mux sources
    // ----------------------------------------------------------------------
    parameter sel_t Z_ZERO    = 2'd0;       // Constant zero
    parameter sel_t Z_CASCADE = 2'd1;       // Cascade in, unconnected here
    parameter sel_t Z_PREV_P  = 2'd2;       // Current p
    parameter sel_t Z_C       = 2'd3;       // Delayed c

endpackage : mac_opcode_pkg

// File: design/mac_preadd_mult.sv
`timescale 1ns/1ns

module mac_preadd_mult
    import mac_width_pkg::*, mac_opcode_pkg::*;
#(
    parameter int AB_W = DEF_AB_W,                  // Width of a and b
    parameter int P_W  = DEF_P_W                    // Width of c and the concat word
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [7:0]               op,            // Op word, sampled with the operands
    input  logic signed [AB_W-1:0]   a,
    input  logic signed [AB_W-1:0]   b,
    input  logic signed [P_W-1:0]    c,
    output logic signed [2*AB_W-1:0] m,             // M register
    output logic [P_W-1:0]           ab_cat,        // a:b after preadder, zero-extended
    output logic signed [P_W-1:0]    c_m,           // c, two edges late
    output logic                     post_sub,      // Late op fields, aligned with m
    output logic                     carry_in,
    output sel_t                     x_sel,
    output sel_t                     z_sel
);

    localparam int M_W   = 2*AB_W;                  // Product width
    localparam int PAD_W = P_W - M_W;               // Zero pad above the concat

    // ----------------------------------------------------------------------
    // Preadder, acts on the live b before the A/B registers
    // ----------------------------------------------------------------------
    logic                   pre_neg;                // D - B selected
    logic signed [AB_W-1:0] b_pre;                  // b after preadder

    assign pre_neg = op[OP_USE_PRE] & op[OP_PRE_SUB];
    // D port is zero, so D - B reduces to -B. Same width as b, so
    // full-scale negative wraps onto itself like the slice preadder
    assign b_pre   = pre_neg ? -b : b;

    // ----------------------------------------------------------------------
    // Edge k: operand registers plus first delay of c and late op bits
    // ----------------------------------------------------------------------
    logic signed [AB_W-1:0] a_r;                    // A1 register
    logic signed [AB_W-1:0] b_r;                    // B1 register
    logic signed [P_W-1:0]  c_d1;                   // First c delay
    logic                   post_sub_d1;            // First delay of bit 7
    logic                   carry_in_d1;            // First delay of bit 5
    sel_t                   x_sel_d1;               // First delay of bits 1:0
    sel_t                   z_sel_d1;               // First delay of bits 3:2

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            a_r         <= '0;
            b_r         <= '0;
            c_d1        <= '0;
            post_sub_d1 <= 1'b0;
            carry_in_d1 <= 1'b0;
            x_sel_d1    <= X_ZERO;                  // Idle op reads zero
            z_sel_d1    <= Z_ZERO;
        end else begin
            a_r         <= a;
            b_r         <= b_pre;
            c_d1        <= c;
            post_sub_d1 <= op[OP_POST_SUB];
            carry_in_d1 <= op[OP_CARRY_IN];
            x_sel_d1    <= op[OP_X_HI:OP_X_LO];
            z_sel_d1    <= op[OP_Z_HI:OP_Z_LO];
        end
    end

    // ----------------------------------------------------------------------
    // Edge k+1: multiplier register, concat and opmode register
    // ----------------------------------------------------------------------
    logic signed [M_W-1:0] prod;                    // Full signed product
    logic [M_W-1:0]        cat_w;                   // Raw a:b bits

    assign prod  = a_r * b_r;                       // Both signed, sized to M_W
    assign cat_w = {a_r, b_r};                      // a high, b low

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            m        <= '0;
            ab_cat   <= '0;
            c_m      <= '0;
            post_sub <= 1'b0;
            carry_in <= 1'b0;
            x_sel    <= X_ZERO;
            z_sel    <= Z_ZERO;
        end else begin
            m        <= prod;
            ab_cat   <= {{PAD_W{1'b0}}, cat_w};     // D bits of the concat are zero
            c_m      <= c_d1;                       // C register lines up with M
            post_sub <= post_sub_d1;
            carry_in <= carry_in_d1;
            x_sel    <= x_sel_d1;
            z_sel    <= z_sel_d1;
        end
    end

endmodule : mac_preadd_mult

// File: design/mac_postadd.sv
`timescale 1ns/1ns

module mac_postadd
    import mac_width_pkg::*, mac_opcode_pkg::*;
#(
    parameter int P_W  = DEF_P_W,                   // Width of c, concat and p
    parameter int AB_W = DEF_AB_W                   // Operand width, sets product size
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic signed [2*AB_W-1:0] m,             // Registered product
    input  logic [P_W-1:0]           ab_cat,        // Zero-extended a:b
    input  logic signed [P_W-1:0]    c_m,           // Delayed c
    input  logic                     post_sub,      // Subtract mode
    input  logic                     carry_in,      // Add one
    input  sel_t                     x_sel,         // X mux select
    input  sel_t                     z_sel,         // Z mux select
    output logic signed [P_W-1:0]    p              // P register
);

    localparam int M_W  = 2*AB_W;                   // Product width
    localparam int EXT_W = P_W - M_W;               // Sign-extension bits above m

    // ----------------------------------------------------------------------
    // X multiplexer
    // ----------------------------------------------------------------------
    logic [P_W-1:0] m_ext;                          // Product on the wide bus
    logic [P_W-1:0] x_val;                          // Selected X operand

    assign m_ext = {{EXT_W{m[M_W-1]}}, m};          // Keep product sign

    always_comb begin
        case (x_sel)
            X_MULT:   x_val = m_ext;
            X_PREV_P: x_val = p;                    // Feedback of the current result
            X_CONCAT: x_val = ab_cat;
            default:  x_val = '0;                   // X_ZERO
        endcase
    end

    // ----------------------------------------------------------------------
    // Z multiplexer
    // ----------------------------------------------------------------------
    logic [P_W-1:0] z_val;                          // Selected Z operand

    always_comb begin
        case (z_sel)
            Z_PREV_P:  z_val = p;
            Z_C:       z_val = c_m;
            default:   z_val = '0;                  // Z_ZERO or the unconnected cascade
        endcase
    end

    // ----------------------------------------------------------------------
    // Postadder / subtractor
    // ----------------------------------------------------------------------
    logic [P_W-1:0] x_cin;                          // X with carry folded in
    logic [P_W-1:0] p_next;                         // Result before the P register

    assign x_cin = x_val + {{(P_W-1){1'b0}}, carry_in};

    // Carry goes with X on both paths, so subtract is Z - (X + cin).
    // Everything wraps modulo 2^P_W, no carry-out is kept
    assign p_next = post_sub ? (z_val - x_cin) : (z_val + x_cin);

    // ----------------------------------------------------------------------
    // P register, edge k+2 of the instruction
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            p <= '0;
        end else begin
            p <= p_next;                            // PREV_P saw the value just before this edge
        end
    end

endmodule : mac_postadd

// File: design/mac_top.sv
`timescale 1ns/1ns

module mac_top
    import mac_width_pkg::*, mac_opcode_pkg::*;
#(
    parameter int AB_W = DEF_AB_W,                  // Width of a and b
    parameter int P_W  = DEF_P_W                    // Width of c and p
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [7:0]             op,              // One instruction per clock
    input  logic signed [AB_W-1:0] a,
    input  logic signed [AB_W-1:0] b,
    input  logic signed [P_W-1:0]  c,
    output logic signed [P_W-1:0]  p               // Result, three edges after issue
);

    // ----------------------------------------------------------------------
    // Stage 1 to stage 2 wires
    // ----------------------------------------------------------------------
    logic signed [2*AB_W-1:0] m;                    // Product
    logic [P_W-1:0]           ab_cat;               // Concat operand
    logic signed [P_W-1:0]    c_m;                  // Aligned c
    logic                     post_sub;
    logic                     carry_in;
    sel_t                     x_sel;
    sel_t                     z_sel;

    mac_preadd_mult #(
        .AB_W     (AB_W),
        .P_W      (P_W)
    ) u_preadd_mult (
        .clk      (clk),
        .reset    (reset),
        .op       (op),
        .a        (a),
        .b        (b),
        .c        (c),
        .m        (m),
        .ab_cat   (ab_cat),
        .c_m      (c_m),
        .post_sub (post_sub),
        .carry_in (carry_in),
        .x_sel    (x_sel),
        .z_sel    (z_sel)
    );

    mac_postadd #(
        .P_W      (P_W),
        .AB_W     (AB_W)
    ) u_postadd (
        .clk      (clk),
        .reset    (reset),
        .m        (m),
        .ab_cat   (ab_cat),
        .c_m      (c_m),
        .post_sub (post_sub),
        .carry_in (carry_in),
        .x_sel    (x_sel),
        .z_sel    (z_sel),
        .p        (p)
    );

endmodule : mac_top

// File: sim/mac_sva.sv
`timescale 1ns/1ns

module mac_sva
    import mac_opcode_pkg::*;
#(
    parameter int P_W = 48                          // Result width
) (
    input logic                  clk,
    input logic                  reset,
    input logic                  carry_in,
    input sel_t                  x_sel,
    input sel_t                  z_sel,
    input logic signed [P_W-1:0] p
);

    // ----------------------------------------------------------------------
    // P register behaviour around reset and idle ops
    // ----------------------------------------------------------------------

    // Held reset leaves the P register cleared
    a_reset_clears_p : assert property (@(posedge clk) reset |=> p == '0)
        else $error("p not zero after a reset cycle");

    // Both muxes at zero and no carry, result must be zero either way
    a_idle_op_gives_zero : assert property (@(posedge clk) disable iff (reset)
        (x_sel == X_ZERO && z_sel == Z_ZERO && !carry_in) |=> p == '0)
        else $error("p not zero after an all-zero postadder op");

    a_p_known : assert property (@(posedge clk) disable iff (reset) !$isunknown(p))
        else $error("p has unknown bits out of reset");

endmodule : mac_sva

bind mac_postadd mac_sva #(
    .P_W      (P_W)
) u_sva (
    .clk      (clk),
    .reset    (reset),
    .carry_in (carry_in),
    .x_sel    (x_sel),
    .z_sel    (z_sel),
    .p        (p)
);

// File: sim/mac_tb.sv
`timescale 1ns/1ns

module mac_tb
    import mac_width_pkg::*, mac_opcode_pkg::*;
;

    localparam int AB_W        = DEF_AB_W;
    localparam int P_W         = DEF_P_W;
    localparam int N_RESET     = 3;                 // Reset cycles
    localparam int N_DIRECTED  = 24;                // Upper bound on directed ops
    localparam int N_RANDOM    = 400;
    localparam int N_FLUSH     = 4;                 // Idle ops to drain the pipe
    localparam int WATCHDOG_NS = (N_RESET + N_DIRECTED + N_RANDOM + N_FLUSH) * 20 + 400;

    localparam logic signed [AB_W-1:0] AB_MIN = {1'b1, {(AB_W-1){1'b0}}};   // -2^17
    localparam logic signed [AB_W-1:0] AB_MAX = {1'b0, {(AB_W-1){1'b1}}};   // 2^17 - 1

    logic                   clk;
    logic                   reset;
    logic [7:0]             op;
    logic signed [AB_W-1:0] a;
    logic signed [AB_W-1:0] b;
    logic signed [P_W-1:0]  c;
    logic signed [P_W-1:0]  p;

    mac_top #(.AB_W(AB_W), .P_W(P_W)) uut (
        .clk   (clk),
        .reset (reset),
        .op    (op),
        .a     (a),
        .b     (b),
        .c     (c),
        .p     (p)
    );

    always #10 clk = ~clk;                          // 20 ns period

    // ----------------------------------------------------------------------
    // Reference model, two sampled instructions in flight plus model p
    // ----------------------------------------------------------------------
    logic [7:0]             pipe_op [0:1];
    logic signed [AB_W-1:0] pipe_a  [0:1];
    logic signed [AB_W-1:0] pipe_b  [0:1];          // b after preadder
    logic [P_W-1:0]         pipe_c  [0:1];
    logic [P_W-1:0]         model_p;
    logic [31:0]            lfsr;
    int                     n_checks;
    int                     n_errors;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [P_W-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[P_W-2:0], lfsr[0]};
        end
    endtask

    function automatic logic [7:0] build_op(input logic post_sub, input logic pre_sub,
                                            input logic cin, input logic use_pre,
                                            input sel_t zs, input sel_t xs);
        return {post_sub, pre_sub, cin, use_pre, zs, xs};
    endfunction

    function automatic logic signed [AB_W-1:0] preadd_b(input logic [7:0] o,
                                                        input logic signed [AB_W-1:0] bv);
        if (o[OP_USE_PRE] && o[OP_PRE_SUB]) begin
            return -bv;                             // D is zero, D - B
        end
        return bv;
    endfunction

    task automatic check_val(input string name, input logic [P_W-1:0] exp_v,
                             input logic [P_W-1:0] act_v);
        n_checks++;
        if (act_v !== exp_v) begin
            n_errors++;
            $display("[FAIL] %s expected %h got %h at %0t ns", name, exp_v, act_v, $time);
        end
    endtask

    // Oldest instruction hits the postadder, then the pipe shifts
    task automatic model_step;
        logic signed [63:0] prod64;
        logic [P_W-1:0]     x_val;
        logic [P_W-1:0]     z_val;
        logic [P_W-1:0]     cin_w;
        prod64 = longint'(pipe_a[1]) * longint'(pipe_b[1]);
        cin_w  = {{(P_W-1){1'b0}}, pipe_op[1][OP_CARRY_IN]};
        case (sel_t'(pipe_op[1][OP_X_HI:OP_X_LO]))
            X_MULT:   x_val = prod64[P_W-1:0];
            X_PREV_P: x_val = model_p;
            X_CONCAT: x_val = {{(P_W-2*AB_W){1'b0}}, pipe_a[1], pipe_b[1]};
            default:  x_val = '0;
        endcase
        case (sel_t'(pipe_op[1][OP_Z_HI:OP_Z_LO]))
            Z_PREV_P:  z_val = model_p;
            Z_C:       z_val = pipe_c[1];
            default:   z_val = '0;                  // Zero, and the cascade is not connected
        endcase
        if (pipe_op[1][OP_POST_SUB]) begin
            model_p = z_val - (x_val + cin_w);
        end else begin
            model_p = z_val + x_val + cin_w;
        end
        pipe_op[1] = pipe_op[0];
        pipe_a[1]  = pipe_a[0];
        pipe_b[1]  = pipe_b[0];
        pipe_c[1]  = pipe_c[0];
        pipe_op[0] = op;                            // Values the DUT samples at this edge
        pipe_a[0]  = a;
        pipe_b[0]  = preadd_b(op, b);
        pipe_c[0]  = c;
    endtask

    // Drive one instruction, check p once the edge has settled
    task automatic issue(input logic [7:0] o, input logic signed [AB_W-1:0] av,
                         input logic signed [AB_W-1:0] bv, input logic [P_W-1:0] cv);
        @(posedge clk);
        model_step();
        op <= o;
        a  <= av;
        b  <= bv;
        c  <= cv;
        @(negedge clk);
        check_val("p", model_p, p);
    endtask

    // X and Z weighted toward MULT, C and PREV_P
    task automatic random_op(output logic [7:0] o);
        logic [P_W-1:0] r;
        sel_t           xs;
        sel_t           zs;
        draw_bits(3, r);
        case (r[2:0])
            3'd0:       xs = X_ZERO;
            3'd4, 3'd5: xs = X_PREV_P;
            3'd6:       xs = X_CONCAT;
            default:    xs = X_MULT;
        endcase
        draw_bits(3, r);
        case (r[2:0])
            3'd0, 3'd7:       zs = Z_ZERO;
            3'd1:             zs = Z_CASCADE;
            3'd5, 3'd6:       zs = Z_PREV_P;
            default:          zs = Z_C;
        endcase
        draw_bits(4, r);
        o = {r[3:0], zs, xs};
    endtask

    initial begin
        logic [7:0]             o;
        logic [P_W-1:0]         r;
        logic signed [AB_W-1:0] av;
        logic signed [AB_W-1:0] bv;
        clk      = 1'b0;
        reset    = 1'b1;
        op       = '0;
        a        = '0;
        b        = '0;
        c        = '0;
        lfsr     = 32'hf4b1_e58f;
        model_p  = '0;
        n_checks = 0;
        n_errors = 0;
        for (int i = 0; i < 2; i++) begin
            pipe_op[i] = '0;
            pipe_a[i]  = '0;
            pipe_b[i]  = '0;
            pipe_c[i]  = '0;
        end

        for (int i = 0; i < N_RESET; i++) begin
            @(posedge clk);
            if (i == N_RESET - 1) reset <= 1'b0;    // Release on the last reset edge
            @(negedge clk);
            check_val("p", '0, p);
        end

        // Extreme products, preadder negation wraps at -2^17
        issue(build_op(0, 0, 0, 0, Z_ZERO, X_MULT), AB_MIN, AB_MIN, '0);
        issue(build_op(0, 1, 0, 1, Z_ZERO, X_MULT), AB_MAX, AB_MIN, '0);
        issue(build_op(0, 1, 0, 1, Z_ZERO, X_MULT), AB_MIN, AB_MAX, '0);
        issue(build_op(0, 0, 0, 0, Z_ZERO, X_MULT), AB_MAX, AB_MAX, '0);
        // Multiply-add and subtract with carry
        issue(build_op(0, 0, 0, 0, Z_C, X_MULT), 18'sd12345, -18'sd678, 48'h0000_1234_5678);
        issue(build_op(1, 0, 1, 0, Z_C, X_MULT), AB_MIN, AB_MAX, 48'h8000_0000_0001);
        issue(build_op(1, 0, 1, 0, Z_C, X_MULT), 18'sd3, 18'sd5, '0);
        // Back-to-back accumulate
        issue(build_op(0, 0, 0, 0, Z_ZERO, X_MULT), 18'sd100, 18'sd200, '0);
        for (int i = 0; i < 5; i++) begin
            issue(build_op(0, 0, 0, 0, Z_PREV_P, X_MULT), AB_W'(i * 1000 + 7),
                  AB_W'(-(i + 3) * 511), '0);
        end
        // Concat path, then doubling
        issue(build_op(0, 0, 1, 0, Z_C, X_CONCAT), 18'sh2aaaa, 18'sh15555, 48'h1);
        issue(build_op(0, 1, 0, 1, Z_ZERO, X_CONCAT), -18'sd1, 18'sd1, '0);
        for (int i = 0; i < 3; i++) begin
            issue(build_op(0, 0, 0, 0, Z_PREV_P, X_PREV_P), '0, '0, '0);
        end
        // Cascade source reads zero
        issue(build_op(0, 0, 0, 0, Z_CASCADE, X_MULT), 18'sd999, 18'sd999, 48'hffff);
        issue(build_op(0, 0, 1, 0, Z_CASCADE, X_CONCAT), 18'sd5, 18'sd6, 48'hffff);
        issue(build_op(1, 0, 0, 0, Z_CASCADE, X_ZERO), '0, '0, 48'hffff);

        for (int i = 0; i < N_RANDOM; i++) begin
            random_op(o);
            draw_bits(AB_W, r);
            av = r[AB_W-1:0];
            draw_bits(AB_W, r);
            bv = r[AB_W-1:0];
            draw_bits(P_W, r);
            issue(o, av, bv, r);
        end
        for (int i = 0; i < N_FLUSH; i++) begin
            issue('0, '0, '0, '0);
        end

        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // ----------------------------------------------------------------------
    // Watchdog
    // ----------------------------------------------------------------------
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired: the test sequence did not finish in time");
        $display("Done: errors found");
        $finish;
    end

endmodule : mac_tb

// File: mac_dsp.f
design/mac_width_pkg.sv
design/mac_opcode_pkg.sv
design/mac_preadd_mult.sv
design/mac_postadd.sv
design/mac_top.sv
sim/mac_sva.sv
sim/mac_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the multiply-add testbench with Verilator.
# Run from the project root.

LOG=sim.log

verilator --binary --timing --assert \
    --top-module mac_tb \
    -f mac_dsp.f \
    -o mac_sim \
    && ./obj_dir/mac_sim > "$LOG" 2>&1 \
    || { echo "Build or simulation run failed, see $LOG"; exit 1; }

cat "$LOG"

grep -q "Done: errors found" "$LOG" \
    && { echo "Simulation failed"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
